// ==== logic/mlpPkg.sv ====
package mlpPkg;

	// value widths and layer sizes.
	localparam int dataWidth = 16;
	localparam int numInputs = 15;
	localparam int numHidden = 4;
	localparam int numOutputs = 3;

	// one fixed-point value, two's complement, wraps on overflow.
	typedef logic [dataWidth-1:0] fixT;

	typedef fixT [0:numInputs-1] featureVecT;
	typedef fixT [0:numHidden-1] hiddenVecT;
	typedef fixT [0:numOutputs-1] scoreVecT;

	typedef logic [1:0] classT; // index of the winning output.

	// weight tables, one row per neuron.
	typedef fixT [0:numHidden-1][0:numInputs-1] hiddenTableT;
	typedef fixT [0:numOutputs-1][0:numHidden-1] outputTableT;

	// hidden layer, neuron 0 is the original trained node.
	localparam hiddenTableT hiddenWeights = '{
		'{
			16'sd939, -16'sd30, 16'sd594, -16'sd107, 16'sd135,
			-16'sd341, 16'sd834, 16'sd41, -16'sd6, 16'sd388,
			16'sd866, 16'sd206, -16'sd42, -16'sd98, -16'sd36
		},
		'{
			16'sd120, 16'sd455, -16'sd210, 16'sd77, 16'sd310,
			-16'sd95, 16'sd18, 16'sd260, -16'sd400, 16'sd55,
			16'sd130, -16'sd12, 16'sd600, 16'sd44, -16'sd180
		},
		'{
			-16'sd250, 16'sd80, 16'sd144, 16'sd512, -16'sd33,
			16'sd201, -16'sd77, 16'sd390, 16'sd66, -16'sd310,
			16'sd25, 16'sd470, 16'sd9, -16'sd140, 16'sd222
		},
		'{
			16'sd61, -16'sd500, 16'sd303, 16'sd29, -16'sd88,
			16'sd415, 16'sd150, -16'sd64, 16'sd277, 16'sd12,
			-16'sd199, 16'sd87, 16'sd340, 16'sd505, 16'sd7
		}
	};

	localparam hiddenVecT hiddenBias = '{
		16'sd88,
		-16'sd50,
		16'sd120,
		16'sd16
	};

	// output layer, one row per class.
	localparam outputTableT outputWeights = '{
		'{16'sd210, -16'sd45, 16'sd130, 16'sd88},
		'{-16'sd60, 16'sd175, 16'sd95, -16'sd20},
		'{16'sd140, 16'sd60, -16'sd110, 16'sd190}
	};

	localparam scoreVecT outputBias = '{
		16'sd40,
		16'sd15,
		-16'sd25
	};

endpackage

// ==== logic/neuron.sv ====
`timescale 1ns/1ns

// three-stage neuron: input register, weighted sum, relu.
module neuron #(
	parameter int fanIn = mlpPkg::numInputs,
	parameter mlpPkg::fixT [0:fanIn-1] weights = '0,
	parameter mlpPkg::fixT bias = '0
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fixT [0:fanIn-1] activations,
	output mlpPkg::fixT result
);

	localparam int signBit = mlpPkg::dataWidth - 1;

	mlpPkg::fixT [0:fanIn-1] actReg; // stage 1.
	mlpPkg::fixT [0:fanIn-1] products;
	mlpPkg::fixT sumNext;
	mlpPkg::fixT sumReg; // stage 2.
	logic sumNegative;

	// low 16 bits of each product.
	always_comb
	begin
		for (int i = 0; i < fanIn; i++)
		begin
			products[i] = actReg[i] * weights[i];
		end
	end

	// bias first, then every product, all wrapping.
	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + products[i];
		end
	end

	assign sumNegative = sumReg[signBit];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= activations;
			sumReg <= sumNext;
			result <= sumNegative ? '0 : sumReg; // relu.
		end
	end

endmodule

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ns

// a row of neurons fed by one shared input vector.
module denseLayer #(
	parameter int fanIn = mlpPkg::numInputs,
	parameter int width = mlpPkg::numHidden,
	parameter mlpPkg::fixT [0:width-1][0:fanIn-1] weights = '0,
	parameter mlpPkg::fixT [0:width-1] bias = '0
) (
	input logic clk,
	input logic reset,
	input mlpPkg::fixT [0:fanIn-1] activations,
	output mlpPkg::fixT [0:width-1] results
);

	// each neuron gets its own weight row and bias entry.
	for (genvar n = 0; n < width; n++)
	begin : gNeuron
		neuron #(
			.fanIn(fanIn),
			.weights(weights[n]),
			.bias(bias[n])
		) neuron_i (
			.clk(clk),
			.reset(reset),
			.activations(activations),
			.result(results[n])
		);
	end

endmodule

// ==== logic/argMax.sv ====
`timescale 1ns/1ns

// picks the largest score, compared unsigned.
module argMax #(
	parameter int width = mlpPkg::numOutputs
) (
	input logic clk,
	input logic reset,
	input mlpPkg::scoreVecT scores,
	output mlpPkg::classT classIdx,
	output mlpPkg::fixT classScore
);

	typedef struct packed {
		mlpPkg::classT idx;
		mlpPkg::fixT score;
	} winnerT;

	winnerT best;
	winnerT bestReg;

	// strict compare keeps the lowest index on a tie.
	always_comb
	begin
		best.idx = '0;
		best.score = scores[0];
		for (int i = 1; i < width; i++)
		begin
			if (scores[i] > best.score)
			begin
				best.idx = mlpPkg::classT'(i);
				best.score = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestReg <= '0;
		end
		else
		begin
			bestReg <= best;
		end
	end

	assign classIdx = bestReg.idx;
	assign classScore = bestReg.score;

endmodule

// ==== logic/mlpInference.sv ====
`timescale 1ns/1ns

// features -> hidden layer -> output layer -> arg-max, seven cycles in all.
module mlpInference #(
	parameter mlpPkg::hiddenTableT hiddenW = mlpPkg::hiddenWeights,
	parameter mlpPkg::hiddenVecT hiddenB = mlpPkg::hiddenBias,
	parameter mlpPkg::outputTableT outputW = mlpPkg::outputWeights,
	parameter mlpPkg::scoreVecT outputB = mlpPkg::outputBias
) (
	input logic clk,
	input logic reset,
	input mlpPkg::featureVecT features,
	output mlpPkg::scoreVecT scores,
	output mlpPkg::classT classIdx,
	output mlpPkg::fixT classScore
);

	mlpPkg::hiddenVecT hidden; // three cycles after features.

	denseLayer #(
		.fanIn(mlpPkg::numInputs),
		.width(mlpPkg::numHidden),
		.weights(hiddenW),
		.bias(hiddenB)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.activations(features),
		.results(hidden)
	);

	denseLayer #(
		.fanIn(mlpPkg::numHidden),
		.width(mlpPkg::numOutputs),
		.weights(outputW),
		.bias(outputB)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.activations(hidden),
		.results(scores)
	);

	argMax #(
		.width(mlpPkg::numOutputs)
	) argMax_i (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIdx(classIdx),
		.classScore(classScore)
	);

endmodule

// ==== sim/mlpModel.svh ====
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// expected values for one feature vector.
typedef struct packed {
	mlpPkg::hiddenVecT hidden;
	mlpPkg::scoreVecT scores;
	mlpPkg::classT idx;
	mlpPkg::fixT score;
} expectT;

// zero when the sign bit is set.
function automatic mlpPkg::fixT relu(input mlpPkg::fixT sum);
	return sum[mlpPkg::dataWidth-1] ? '0 : sum;
endfunction

// full product, then keep the low half.
function automatic mlpPkg::fixT wrapMul(input mlpPkg::fixT a, input mlpPkg::fixT b);
	logic [2*mlpPkg::dataWidth-1:0] full;
	full = {{mlpPkg::dataWidth{1'b0}}, a} * {{mlpPkg::dataWidth{1'b0}}, b};
	return full[mlpPkg::dataWidth-1:0];
endfunction

function automatic mlpPkg::hiddenVecT hiddenLayerOut(input mlpPkg::featureVecT x);
	mlpPkg::hiddenVecT h;
	mlpPkg::fixT sum;
	for (int n = 0; n < mlpPkg::numHidden; n++)
	begin
		sum = mlpPkg::hiddenBias[n];
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			sum = sum + wrapMul(x[i], mlpPkg::hiddenWeights[n][i]); // wraps at 16 bits.
		end
		h[n] = relu(sum);
	end
	return h;
endfunction

function automatic mlpPkg::scoreVecT scoreLayerOut(input mlpPkg::hiddenVecT h);
	mlpPkg::scoreVecT s;
	mlpPkg::fixT sum;
	for (int n = 0; n < mlpPkg::numOutputs; n++)
	begin
		sum = mlpPkg::outputBias[n];
		for (int i = 0; i < mlpPkg::numHidden; i++)
		begin
			sum = sum + wrapMul(h[i], mlpPkg::outputWeights[n][i]);
		end
		s[n] = relu(sum);
	end
	return s;
endfunction

// largest unsigned score first, then the first index that holds it.
function automatic expectT resultFromScores(input mlpPkg::hiddenVecT h,
		input mlpPkg::scoreVecT s);
	expectT r;
	r.hidden = h;
	r.scores = s;
	r.score = '0;
	for (int i = 0; i < mlpPkg::numOutputs; i++)
	begin
		if (s[i] > r.score)
			r.score = s[i];
	end
	r.idx = '0;
	for (int i = mlpPkg::numOutputs - 1; i >= 0; i--)
	begin
		if (s[i] == r.score)
			r.idx = mlpPkg::classT'(i);
	end
	return r;
endfunction

function automatic expectT inferVector(input mlpPkg::featureVecT x);
	mlpPkg::hiddenVecT h;
	h = hiddenLayerOut(x);
	return resultFromScores(h, scoreLayerOut(h));
endfunction

// how many scores share the top value.
function automatic int topCount(input expectT r);
	int count;
	count = 0;
	for (int i = 0; i < mlpPkg::numOutputs; i++)
	begin
		if (r.scores[i] == r.score)
			count++;
	end
	return count;
endfunction

// true when a hidden or score value came out zero.
function automatic bit anyZero(input expectT r);
	bit zero;
	zero = 1'b0;
	for (int n = 0; n < mlpPkg::numHidden; n++)
	begin
		if (r.hidden[n] == '0)
			zero = 1'b1;
	end
	for (int n = 0; n < mlpPkg::numOutputs; n++)
	begin
		if (r.scores[n] == '0)
			zero = 1'b1;
	end
	return zero;
endfunction

`endif

// ==== sim/mlpTb.sv ====
`timescale 1ns/1ns

module mlpTb;

	localparam int drainCycles = 8; // covers the seven cycle latency.
	localparam int resetCycles = 16;
	localparam int zeroCycles = 10;
	localparam int clipCycles = 30;
	localparam int burstCycles = 200;
	localparam int wrapCycles = 24;
	localparam int tieCycles = 12;
	localparam int runLimit = resetCycles + zeroCycles + clipCycles + burstCycles
		+ wrapCycles + tieCycles + 6 * drainCycles + 50;

	logic clk = 1'b0;
	logic reset;
	mlpPkg::featureVecT features;
	mlpPkg::scoreVecT scores;
	mlpPkg::classT classIdx;
	mlpPkg::fixT classScore;

	`include "mlpModel.svh"

	expectT hist [0:6]; // hist[k] holds the vector sampled k edges ago.
	expectT zeroResult;
	expectT biasResult;
	expectT expNow;
	int sinceReset = 0;
	int cycleCount = 0;
	logic [31:0] rngState = 32'd65;
	string testName = "reset";
	int errorCount = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int vectorCount = 0;

	mlpInference mlpInference_i (
		.clk(clk),
		.reset(reset),
		.features(features),
		.scores(scores),
		.classIdx(classIdx),
		.classScore(classScore)
	);

	always #5 clk = ~clk;

	assign zeroResult = inferVector('0);
	assign biasResult = resultFromScores('0, scoreLayerOut('0)); // layers fed by cleared registers.

	// after reset the stages refill one by one before the line of vectors takes over.
	always_comb
	begin
		expNow = hist[6];
		if (sinceReset <= 1)
			expNow.scores = '0;
		else if (sinceReset <= 4)
			expNow.scores = biasResult.scores;
		else if (sinceReset == 5)
			expNow.scores = zeroResult.scores;
		else
			expNow.scores = hist[5].scores;
		if (sinceReset <= 2)
		begin
			expNow.idx = '0;
			expNow.score = '0;
		end
		else if (sinceReset <= 5)
		begin
			expNow.idx = biasResult.idx;
			expNow.score = biasResult.score;
		end
		else if (sinceReset == 6)
		begin
			expNow.idx = zeroResult.idx;
			expNow.score = zeroResult.score;
		end
	end

	always @(posedge clk)
	begin
		for (int k = 6; k > 0; k--)
		begin
			hist[k] <= hist[k-1];
		end
		hist[0] <= inferVector(features);
		if (reset)
			sinceReset <= 0;
		else if (sinceReset < 1000)
			sinceReset <= sinceReset + 1;
		cycleCount <= cycleCount + 1;
		if (cycleCount >= runLimit)
		begin
			$display("timeout: the run did not finish within %0d cycles", runLimit);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic reportMismatch(input string signal, input logic [47:0] expected,
			input logic [47:0] actual);
		errorCount++;
		testErrors++;
		$display("ERROR %s: %s expected %h, actual %h", testName, signal, expected, actual);
	endtask

	task automatic reportFailure(input string message);
		errorCount++;
		testErrors++;
		$display("test %s: %s", testName, message);
	endtask

	// outputs settle long before the falling edge.
	scoresCheck: assert property (@(negedge clk) scores == expNow.scores)
		else reportMismatch("scores", 48'(expNow.scores), 48'(scores));
	classIdxCheck: assert property (@(negedge clk) classIdx == expNow.idx)
		else reportMismatch("classIdx", 48'(expNow.idx), 48'(classIdx));
	classScoreCheck: assert property (@(negedge clk) classScore == expNow.score)
		else reportMismatch("classScore", 48'(expNow.score), 48'(classScore));

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic mlpPkg::fixT nextRandom();
		rngState = xorshift(rngState);
		return rngState[31:16];
	endfunction

	function automatic mlpPkg::featureVecT randomVector(input mlpPkg::fixT mask);
		mlpPkg::featureVecT v;
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			v[i] = nextRandom() & mask;
		end
		return v;
	endfunction

	// each value sits just inside positive or negative full scale.
	function automatic mlpPkg::featureVecT nearFullVector();
		mlpPkg::featureVecT v;
		mlpPkg::fixT r;
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			r = nextRandom();
			v[i] = r[15] ? {8'h80, r[7:0]} : {8'h7f, r[7:0]};
		end
		return v;
	endfunction

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
		vectorCount = 0;
	endtask

	task automatic applyVector(input mlpPkg::featureVecT v);
		@(posedge clk);
		#1;
		features = v;
		vectorCount++;
	endtask

	task automatic finishTest();
		repeat (drainCycles) @(posedge clk);
		#1;
		testsRun++;
		if (testErrors != 0)
			testsFailed++;
		$display("test %s finished: %0d vectors, %0d errors", testName, vectorCount, testErrors);
	endtask

	initial
	begin
		mlpPkg::featureVecT v;
		expectT r;
		int found;
		int zeroTies;
		reset = 1'b1;
		features = '0;
		startTest("reset");
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (resetCycles - 4) applyVector('0);
		finishTest();

		startTest("zeroBias");
		repeat (zeroCycles) applyVector('0);
		finishTest();

		startTest("reluClip");
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			if (mlpPkg::hiddenWeights[0][i][mlpPkg::dataWidth-1])
			begin
				v = '0;
				v[i] = 16'd60;
				applyVector(v);
				v[i] = 16'd200;
				applyVector(v);
			end
		end
		v = '0;
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			if (mlpPkg::hiddenWeights[0][i][mlpPkg::dataWidth-1])
				v[i] = 16'd20; // every negative weight of neuron 0 at once.
		end
		applyVector(v);
		found = 0;
		for (int t = 0; t < 1000 && found < 8; t++)
		begin
			v = randomVector(16'h03ff);
			r = inferVector(v);
			if (anyZero(r))
			begin
				applyVector(v);
				found++;
			end
		end
		finishTest();

		startTest("burst");
		repeat (burstCycles) applyVector(randomVector(16'hffff));
		finishTest();

		startTest("wrapAround");
		applyVector({mlpPkg::numInputs{16'h7fff}});
		applyVector({mlpPkg::numInputs{16'h8000}});
		applyVector({mlpPkg::numInputs{16'hffff}});
		applyVector({mlpPkg::numInputs{16'h8001}});
		for (int i = 0; i < mlpPkg::numInputs; i++)
		begin
			v[i] = (i % 2 == 0) ? 16'h7fff : 16'h8000;
		end
		applyVector(v);
		repeat (16) applyVector(nearFullVector());
		finishTest();

		startTest("argMaxTie");
		found = 0;
		zeroTies = 0;
		for (int t = 0; t < 20000 && found < tieCycles; t++)
		begin
			v = randomVector(16'hffff);
			r = inferVector(v);
			if (topCount(r) > 1)
			begin
				applyVector(v);
				found++;
				if (r.score == '0)
					zeroTies++;
			end
		end
		if (zeroTies == 0)
			reportFailure("no vector with all-zero scores was found for the tie check");
		finishTest();

		$display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+sim
logic/mlpPkg.sv
logic/neuron.sv
logic/denseLayer.sv
logic/argMax.sv
logic/mlpInference.sv
sim/mlpTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module mlpTb -f project.f -o mlpSim \
	&& ./obj_dir/mlpSim | tee /dev/stderr | grep "PASS: all tests" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
